/* build.f */
+incdir+.
pid_pkg.sv
pid_cfg_regs.sv
oversample_filter.sv
pid_core.sv
output_stage.sv
dac_instr_queue.sv
dac_controller.sv
pid_controller.sv
tb_pid_controller.sv

/* dac_controller.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module dac_controller (
	input logic clk50,
	input logic rst_n,
	input pid_pkg::dac_word_t queue_out,
	output logic dac_done,
	output logic dac_nsync,
	output logic dac_sclk,
	output logic dac_din
);

	localparam int W_BIT = $clog2(`W_DAC_FRAME);
	localparam int W_GAP = $clog2(`DAC_GAP_CYCLES + 1);

	pid_pkg::dac_state_t state_q;
	logic [`W_DAC_FRAME-1:0] frame;
	logic [`W_DAC_FRAME-1:0] shreg_q;	// msb goes out first
	logic [W_BIT-1:0] bit_cnt_q;
	logic [W_GAP-1:0] gap_cnt_q;
	logic ph_q;							// 0 rising sclk next, 1 falling next

	// cmd, zero extended channel, code
	assign frame = {`DAC_CMD_WRITE, {(4 - `W_DAC_CHS){1'b0}}, queue_out.chan, queue_out.code};
	assign dac_done = (state_q == pid_pkg::IDLE) && queue_out.valid;	// accept and pop

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			state_q <= pid_pkg::IDLE;
			dac_nsync <= 1'b1;
			dac_sclk <= 1'b0;
			dac_din <= 1'b0;
			ph_q <= 1'b0;
			bit_cnt_q <= '0;
			gap_cnt_q <= '0;
		end else begin
			case (state_q)
				pid_pkg::IDLE: begin
					if (dac_done) begin
						shreg_q <= frame;
						dac_nsync <= 1'b0;	// frame starts
						ph_q <= 1'b0;
						bit_cnt_q <= '0;
						state_q <= pid_pkg::SHIFT;
					end
				end
				pid_pkg::SHIFT: begin
					if (!ph_q) begin		// rising sclk, new data bit
						dac_sclk <= 1'b1;
						dac_din <= shreg_q[`W_DAC_FRAME-1];
						shreg_q <= {shreg_q[`W_DAC_FRAME-2:0], 1'b0};
						ph_q <= 1'b1;
					end else begin			// falling sclk, dac samples din
						dac_sclk <= 1'b0;
						ph_q <= 1'b0;
						if (bit_cnt_q == W_BIT'(`W_DAC_FRAME - 1)) begin
							gap_cnt_q <= '0;
							state_q <= pid_pkg::GAP;
						end else begin
							bit_cnt_q <= bit_cnt_q + 1'b1;
						end
					end
				end
				pid_pkg::GAP: begin
					dac_nsync <= 1'b1;		// rises one cycle after the last falling edge
					dac_din <= 1'b0;
					if (gap_cnt_q == W_GAP'(`DAC_GAP_CYCLES)) state_q <= pid_pkg::IDLE;
					else gap_cnt_q <= gap_cnt_q + 1'b1;
				end
				default: state_q <= pid_pkg::IDLE;
			endcase
		end
	end

endmodule

/* dac_instr_queue.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module dac_instr_queue (
	input logic clk50,
	input logic rst_n,
	input pid_pkg::dac_word_t opp_out,
	input logic dac_done,
	output pid_pkg::dac_word_t queue_out
);

	logic [`N_DAC-1:0] pend_q;				// slot holds an unsent code
	pid_pkg::dac_code_t slot_q [`N_DAC];	// latest code per dac channel

	// lowest pending channel wins, scan from the top so it is assigned last
	always_comb begin
		queue_out = '0;
		for (int d = `N_DAC - 1; d >= 0; d--) begin
			if (pend_q[d]) begin
				queue_out.valid = 1'b1;
				queue_out.chan = pid_pkg::dac_chan_t'(d);
				queue_out.code = slot_q[d];
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			pend_q <= '0;
		end else begin
			if (dac_done) pend_q[queue_out.chan] <= 1'b0;		// popped by the serializer
			if (opp_out.valid) pend_q[opp_out.chan] <= 1'b1;	// a new word beats the pop
		end
	end

	// a busy serializer just gets the newest value later
	always_ff @(posedge clk50) begin
		if (opp_out.valid) slot_q[opp_out.chan] <= opp_out.code;
	end

endmodule

/* output_stage.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module output_stage (
	input logic clk50,
	input logic rst_n,
	input pid_pkg::pid_cfg_t cfg,
	input pid_pkg::chan_pid_t pid_out,
	output pid_pkg::dac_word_t opp_out
);

	localparam int W_BIAS = `W_PID + 2;		// pid word plus unsigned offset

	pid_pkg::route_t route;					// route of the incoming channel
	logic signed [W_BIAS-1:0] biased;
	pid_pkg::dac_code_t code;

	always_comb begin
		route = cfg.routes[pid_out.chan];
		biased = $signed({1'b0, cfg.oinit}) + $signed(pid_out.data);
		// clamp into [omin, omax]
		if (biased < $signed({1'b0, cfg.omin})) begin
			code = cfg.omin;
		end else if (biased > $signed({1'b0, cfg.omax})) begin
			code = cfg.omax;
		end else begin
			code = biased[`W_DAC_DATA-1:0];
		end
	end

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			opp_out.valid <= 1'b0;
		end else begin
			opp_out.valid <= pid_out.valid & route.active;	// unrouted items die here
			opp_out.chan <= route.dest;
			opp_out.code <= code;
		end
	end

endmodule

/* oversample_filter.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module oversample_filter (
	input logic clk50,
	input logic rst_n,
	input pid_pkg::pid_cfg_t cfg,
	input pid_pkg::chan_sample_t sample_in,
	output pid_pkg::chan_sample_t osf_out
);

	localparam int W_CNT = (1 << `W_OSM) - 1;		// counts up to 2^osm - 1
	localparam int W_ACC = `W_SAMPLE + W_CNT;		// room for 2^max_osm samples

	logic signed [W_ACC-1:0] sum_q [`N_ADC];	// running sum per channel
	logic [W_CNT-1:0] cnt_q [`N_ADC];			// samples taken in this group
	logic signed [W_ACC-1:0] acc_next;
	logic signed [W_ACC-1:0] acc_avg;
	logic [W_CNT-1:0] cnt_last;
	logic grp_done;

	always_comb begin
		acc_next = sum_q[sample_in.chan] + $signed(sample_in.data);	// sign extends
		acc_avg = acc_next >>> cfg.osm;				// divide by 2^osm
		cnt_last = (W_CNT'(1) << cfg.osm) - 1'b1;
		grp_done = cnt_q[sample_in.chan] >= cnt_last;	// >= covers an osm drop mid group
	end

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			osf_out.valid <= 1'b0;
			for (int c = 0; c < `N_ADC; c++) begin
				sum_q[c] <= '0;
				cnt_q[c] <= '0;
			end
		end else begin
			osf_out.valid <= sample_in.valid & grp_done;
			osf_out.chan <= sample_in.chan;
			osf_out.data <= acc_avg[`W_SAMPLE-1:0];
			if (sample_in.valid) begin
				if (grp_done) begin				// group complete, restart
					sum_q[sample_in.chan] <= '0;
					cnt_q[sample_in.chan] <= '0;
				end else begin
					sum_q[sample_in.chan] <= acc_next;
					cnt_q[sample_in.chan] <= cnt_q[sample_in.chan] + 1'b1;
				end
			end
		end
	end

endmodule

/* pid_cfg_regs.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module pid_cfg_regs (
	input logic clk50,
	input logic rst_n,
	input logic [`W_AXI_ADDR-1:0] s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input logic [`W_AXI_DATA-1:0] s_axi_wdata,
	input logic [3:0] s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic [`W_AXI_ADDR-1:0] s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [`W_AXI_DATA-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,
	output pid_pkg::pid_cfg_t cfg
);

	logic wr_hs;							// address and data accepted
	logic rd_hs;
	logic [`W_AXI_DATA-1:0] wr_word;		// old value merged with strobed bytes

	// 32 bit view of a register, unknown addresses give zero
	function automatic logic [`W_AXI_DATA-1:0] reg_word(
		input logic [`W_AXI_ADDR-1:0] addr,
		input pid_pkg::pid_cfg_t c
	);
		logic [`W_AXI_DATA-1:0] w;
		w = '0;
		case (addr)
			`REG_SETP: w[15:0] = c.setpoint;
			`REG_PCF: w[15:0] = c.p_coef;
			`REG_ICF: w[15:0] = c.i_coef;
			`REG_OSM: w[`W_OSM-1:0] = c.osm;
			`REG_OMIN: w[`W_DAC_DATA-1:0] = c.omin;
			`REG_OMAX: w[`W_DAC_DATA-1:0] = c.omax;
			`REG_OINIT: w[`W_DAC_DATA-1:0] = c.oinit;
			`REG_ROUTE: for (int i = 0; i < `N_ADC; i++) w[4*i +: 3] = c.routes[i];
			`REG_CTRL: w[`N_ADC-1:0] = c.lock_en;	// clear bits are write only
			default: w = '0;
		endcase
		return w;
	endfunction

	assign wr_hs = s_axi_awready & s_axi_awvalid & s_axi_wvalid;
	assign rd_hs = s_axi_arready & s_axi_arvalid;
	assign s_axi_bresp = 2'b00;	// always OKAY
	assign s_axi_rresp = 2'b00;

	// byte strobes only touch their own lane
	always_comb begin
		wr_word = reg_word(s_axi_awaddr, cfg);
		for (int b = 0; b < 4; b++) begin
			if (s_axi_wstrb[b]) wr_word[8*b +: 8] = s_axi_wdata[8*b +: 8];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// handshakes and register writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			s_axi_awready <= 1'b0;
			s_axi_wready <= 1'b0;
			s_axi_bvalid <= 1'b0;
			s_axi_arready <= 1'b0;
			s_axi_rvalid <= 1'b0;
			cfg.setpoint <= '0;
			cfg.p_coef <= '0;
			cfg.i_coef <= '0;
			cfg.osm <= `OSM_RST;
			cfg.omin <= `OMIN_RST;
			cfg.omax <= `OMAX_RST;
			cfg.oinit <= `OINIT_RST;
			cfg.routes <= '0;		// all routes inactive
			cfg.lock_en <= '0;
			cfg.clear <= '0;
		end else begin
			// ready pulses once both halves of the write are present
			s_axi_awready <= s_axi_awvalid & s_axi_wvalid & ~s_axi_awready & ~s_axi_bvalid;
			s_axi_wready <= s_axi_awvalid & s_axi_wvalid & ~s_axi_awready & ~s_axi_bvalid;
			s_axi_arready <= s_axi_arvalid & ~s_axi_arready & ~s_axi_rvalid;
			cfg.clear <= '0;	// default, pulse lasts one cycle
			if (wr_hs) s_axi_bvalid <= 1'b1;
			else if (s_axi_bready) s_axi_bvalid <= 1'b0;
			if (rd_hs) begin
				s_axi_rvalid <= 1'b1;
				s_axi_rdata <= reg_word(s_axi_araddr, cfg);
			end else if (s_axi_rready) begin
				s_axi_rvalid <= 1'b0;
			end
			if (wr_hs) begin
				case (s_axi_awaddr)
					`REG_SETP: cfg.setpoint <= wr_word[15:0];
					`REG_PCF: cfg.p_coef <= wr_word[15:0];
					`REG_ICF: cfg.i_coef <= wr_word[15:0];
					`REG_OSM: cfg.osm <= wr_word[`W_OSM-1:0];
					`REG_OMIN: cfg.omin <= wr_word[`W_DAC_DATA-1:0];
					`REG_OMAX: cfg.omax <= wr_word[`W_DAC_DATA-1:0];
					`REG_OINIT: cfg.oinit <= wr_word[`W_DAC_DATA-1:0];
					`REG_ROUTE: begin
						for (int i = 0; i < `N_ADC; i++) cfg.routes[i] <= wr_word[4*i +: 3];
					end
					`REG_CTRL: begin
						cfg.lock_en <= wr_word[`N_ADC-1:0];
						cfg.clear <= wr_word[8 +: `N_ADC];
					end
					default: ;	// writes to unknown addresses are dropped
				endcase
			end
		end
	end

endmodule

/* pid_controller.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module pid_controller (
	input logic clk50,
	input logic rst_n,
	input logic [`W_AXI_ADDR-1:0] s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input logic [`W_AXI_DATA-1:0] s_axi_wdata,
	input logic [3:0] s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic [`W_AXI_ADDR-1:0] s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [`W_AXI_DATA-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,
	input pid_pkg::chan_sample_t sample_in,
	output logic dac_nsync,
	output logic dac_sclk,
	output logic dac_din,
	output logic dac_nldac,
	output logic dac_nclr
);

	pid_pkg::pid_cfg_t cfg;
	pid_pkg::chan_sample_t osf_out;	// averaged samples
	pid_pkg::chan_pid_t pid_out;
	pid_pkg::dac_word_t opp_out;		// routed, clamped codes
	pid_pkg::dac_word_t queue_out;		// word offered to the serializer
	logic dac_done;

	assign dac_nldac = 1'b0;	// outputs update as each frame completes
	assign dac_nclr = 1'b1;		// never clear the dac

	////////////////////////////////////////////////////////////////////////////
	// register block and pipeline
	////////////////////////////////////////////////////////////////////////////

	pid_cfg_regs cfg_regs_inst (
		.clk50 (clk50), .rst_n (rst_n),
		.s_axi_awaddr (s_axi_awaddr), .s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata (s_axi_wdata), .s_axi_wstrb (s_axi_wstrb),
		.s_axi_wvalid (s_axi_wvalid), .s_axi_wready (s_axi_wready),
		.s_axi_bresp (s_axi_bresp), .s_axi_bvalid (s_axi_bvalid),
		.s_axi_bready (s_axi_bready),
		.s_axi_araddr (s_axi_araddr), .s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata (s_axi_rdata), .s_axi_rresp (s_axi_rresp),
		.s_axi_rvalid (s_axi_rvalid), .s_axi_rready (s_axi_rready),
		.cfg (cfg)
	);

	oversample_filter osf_inst (
		.clk50 (clk50), .rst_n (rst_n), .cfg (cfg),
		.sample_in (sample_in), .osf_out (osf_out)
	);

	pid_core pid_inst (
		.clk50 (clk50), .rst_n (rst_n), .cfg (cfg),
		.osf_out (osf_out), .pid_out (pid_out)
	);

	output_stage opp_inst (
		.clk50 (clk50), .rst_n (rst_n), .cfg (cfg),
		.pid_out (pid_out), .opp_out (opp_out)
	);

	dac_instr_queue diq_inst (
		.clk50 (clk50), .rst_n (rst_n), .opp_out (opp_out),
		.dac_done (dac_done), .queue_out (queue_out)
	);

	dac_controller dac_inst (
		.clk50 (clk50), .rst_n (rst_n), .queue_out (queue_out),
		.dac_done (dac_done), .dac_nsync (dac_nsync),
		.dac_sclk (dac_sclk), .dac_din (dac_din)
	);

endmodule

/* pid_core.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module pid_core (
	input logic clk50,
	input logic rst_n,
	input pid_pkg::pid_cfg_t cfg,
	input pid_pkg::chan_sample_t osf_out,
	output pid_pkg::chan_pid_t pid_out
);

	localparam int W_ERR = `W_SAMPLE + 1;					// setpoint minus sample
	localparam int W_PROD = $bits(pid_pkg::coef_t) + W_ERR;
	localparam int W_SUM = `W_INTEG + 2;					// p term plus integrator

	logic signed [`W_INTEG-1:0] integ_q [`N_ADC];	// integrator per channel
	logic signed [W_ERR-1:0] err;
	logic signed [W_PROD-1:0] p_term;
	logic signed [W_PROD-1:0] i_term;
	logic signed [`W_INTEG-1:0] integ_next;
	logic signed [W_SUM-1:0] pid_sum;
	logic signed [W_SUM-1:0] pid_scaled;

	////////////////////////////////////////////////////////////////////////////
	// error and terms for the channel of the incoming sample
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		err = $signed(cfg.setpoint) - $signed(osf_out.data);
		p_term = $signed(cfg.p_coef) * err;
		i_term = $signed(cfg.i_coef) * err;
		integ_next = integ_q[osf_out.chan] + i_term[`W_INTEG-1:0];	// wraps on overflow
		pid_sum = p_term + integ_next;
		pid_scaled = pid_sum >>> `PID_SHIFT;
	end

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			pid_out.valid <= 1'b0;
			for (int c = 0; c < `N_ADC; c++) integ_q[c] <= '0;
		end else begin
			pid_out.valid <= osf_out.valid;
			pid_out.chan <= osf_out.chan;
			// unlocked channels put out zero, so the dac sits at oinit
			pid_out.data <= cfg.lock_en[osf_out.chan] ? pid_scaled[`W_PID-1:0] : '0;
			for (int c = 0; c < `N_ADC; c++) begin
				if (cfg.clear[c] || !cfg.lock_en[c]) begin
					integ_q[c] <= '0;			// held at zero while unlocked
				end else if (osf_out.valid && osf_out.chan == pid_pkg::adc_chan_t'(c)) begin
					integ_q[c] <= integ_next;
				end
			end
		end
	end

endmodule

/* pid_pkg.sv */
`include "pid_settings.svh"

package pid_pkg;

	typedef logic [$clog2(`N_ADC)-1:0] adc_chan_t;	// input channel index
	typedef logic signed [`W_SAMPLE-1:0] sample_t;
	typedef logic signed [`W_PID-1:0] pid_word_t;
	typedef logic [`W_DAC_DATA-1:0] dac_code_t;		// straight binary dac code
	typedef logic [`W_DAC_CHS-1:0] dac_chan_t;
	typedef logic [`W_OSM-1:0] osm_t;				// log2 of samples averaged
	typedef logic signed [15:0] coef_t;

	typedef struct packed {
		logic active;		// 0 drops the channel
		dac_chan_t dest;
	} route_t;

	// adc input and oversample filter output
	typedef struct packed {
		logic valid;
		adc_chan_t chan;
		sample_t data;
	} chan_sample_t;

	typedef struct packed {
		logic valid;
		adc_chan_t chan;
		pid_word_t data;
	} chan_pid_t;

	typedef struct packed {
		logic valid;
		dac_chan_t chan;
		dac_code_t code;
	} dac_word_t;

	// everything the host can set
	typedef struct packed {
		sample_t setpoint;
		coef_t p_coef;
		coef_t i_coef;
		osm_t osm;
		dac_code_t omin;
		dac_code_t omax;
		dac_code_t oinit;
		route_t [`N_ADC-1:0] routes;
		logic [`N_ADC-1:0] lock_en;
		logic [`N_ADC-1:0] clear;		// one cycle integrator clear
	} pid_cfg_t;

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		GAP
	} dac_state_t;

endpackage

/* pid_settings.svh */
`ifndef PID_SETTINGS_SVH
`define PID_SETTINGS_SVH

// channel counts
`define N_ADC           2
`define N_DAC           4

// datapath widths
`define W_SAMPLE        16
`define W_PID           24
`define W_INTEG         32
`define PID_SHIFT       4     // pid sum is scaled down by 2^PID_SHIFT
`define W_OSM           3
`define W_DAC_DATA      16
`define W_DAC_CHS       2

// serial dac frame
`define W_DAC_FRAME     24
`define DAC_CMD_WRITE   4'h3  // write input register and update output
`define DAC_GAP_CYCLES  2     // nsync high time between frames

// axi4-lite register map
`define W_AXI_ADDR      8
`define W_AXI_DATA      32
`define REG_SETP        8'h00
`define REG_PCF         8'h04
`define REG_ICF         8'h08
`define REG_OSM         8'h0C
`define REG_OMIN        8'h10
`define REG_OMAX        8'h14
`define REG_OINIT       8'h18
`define REG_ROUTE       8'h1C  // channel i route in bits [4i+2:4i], {active, dest}
`define REG_CTRL        8'h20  // [N_ADC-1:0] lock enables, [8+i] clear pulse

// reset values of the config
`define OSM_RST         3'd0
`define OMIN_RST        16'h0000
`define OMAX_RST        16'hFFFF
`define OINIT_RST       16'h8000

`endif

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_pid_controller -o sim_pid
./obj_dir/sim_pid | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

/* tb_pid_controller.sv */
`timescale 1ns/10ps
`include "pid_settings.svh"

module tb_pid_controller;

	localparam int N_ENT = 10;
	localparam int N_RB = 11;
	localparam int AXI_TIMEOUT = 50;	// cycles per handshake
	localparam int FRAME_TIMEOUT = 200;	// sample to end of frame is about 60
	localparam int QUIET_CYCLES = 40;	// window where no frame may start

	// one row of the stimulus table
	typedef struct packed {
		pid_pkg::sample_t setp;
		pid_pkg::coef_t p;
		pid_pkg::coef_t i;
		pid_pkg::osm_t osm;
		pid_pkg::dac_code_t omin;
		pid_pkg::dac_code_t omax;
		pid_pkg::dac_code_t oinit;
		logic [7:0] route;		// ROUTE register value
		logic [9:0] ctrl;		// [1:0] lock, [9:8] clear
		pid_pkg::adc_chan_t chan;
		logic [3:0] n_samp;
		pid_pkg::sample_t base;	// sample = base + (random & mask)
		logic [15:0] mask;
	} entry_t;

	// register readback row
	typedef struct packed {
		logic [`W_AXI_ADDR-1:0] addr;
		logic [31:0] wdat;
		logic [31:0] exp;
	} rb_row_t;

	logic clk50;
	logic rst_n;
	logic [`W_AXI_ADDR-1:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [`W_AXI_DATA-1:0] s_axi_wdata;
	logic [3:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [`W_AXI_ADDR-1:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [`W_AXI_DATA-1:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;
	pid_pkg::chan_sample_t sample_in;
	logic dac_nsync;
	logic dac_sclk;
	logic dac_din;
	logic dac_nldac;
	logic dac_nclr;

	entry_t tbl [N_ENT];
	string tname [N_ENT];
	logic [`W_DAC_FRAME-1:0] frames [$];	// decoded serial frames
	int seed;

	// reference model state
	longint osf_sum [`N_ADC];
	int osf_cnt [`N_ADC];
	int integ_m [`N_ADC];

	pid_controller pid_controller_inst (
		.clk50 (clk50), .rst_n (rst_n),
		.s_axi_awaddr (s_axi_awaddr), .s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata (s_axi_wdata), .s_axi_wstrb (s_axi_wstrb),
		.s_axi_wvalid (s_axi_wvalid), .s_axi_wready (s_axi_wready),
		.s_axi_bresp (s_axi_bresp), .s_axi_bvalid (s_axi_bvalid),
		.s_axi_bready (s_axi_bready),
		.s_axi_araddr (s_axi_araddr), .s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata (s_axi_rdata), .s_axi_rresp (s_axi_rresp),
		.s_axi_rvalid (s_axi_rvalid), .s_axi_rready (s_axi_rready),
		.sample_in (sample_in),
		.dac_nsync (dac_nsync), .dac_sclk (dac_sclk), .dac_din (dac_din),
		.dac_nldac (dac_nldac), .dac_nclr (dac_nclr)
	);

	initial begin
		clk50 = 1'b0;
		forever #10 clk50 = ~clk50;	// 50 MHz
	end

	////////////////////////////////////////////////////////////////////////////
	// failure reporting and compares
	////////////////////////////////////////////////////////////////////////////

	task automatic end_with_fail();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			end_with_fail();
		end
	endtask

	task automatic check_code(input string name, input pid_pkg::dac_code_t exp,
			input pid_pkg::dac_code_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected code %h, actual %h", name, exp, act);
			end_with_fail();
		end
	endtask

	task automatic check_chan(input string name, input pid_pkg::dac_chan_t exp,
			input pid_pkg::dac_chan_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected dac channel %0d, actual %0d", name, exp, act);
			end_with_fail();
		end
	endtask

	// single control pins and handshake levels
	task automatic check_pin(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
			end_with_fail();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// axi4-lite master
	////////////////////////////////////////////////////////////////////////////

	task automatic axi_write(input logic [`W_AXI_ADDR-1:0] addr, input logic [31:0] data);
		int t;
		@(posedge clk50);
		s_axi_awaddr <= addr;
		s_axi_awvalid <= 1'b1;
		s_axi_wdata <= data;
		s_axi_wstrb <= 4'hF;
		s_axi_wvalid <= 1'b1;
		s_axi_bready <= 1'b1;
		t = 0;
		@(posedge clk50);
		while (!s_axi_awready) begin	// awready and wready pulse together
			if (t == AXI_TIMEOUT) begin
				$display("timeout: write to address %h was never accepted", addr);
				end_with_fail();
			end
			t++;
			@(posedge clk50);
		end
		check_pin("wready with awready", 1'b1, s_axi_wready);
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid <= 1'b0;
		t = 0;
		@(posedge clk50);
		while (!s_axi_bvalid) begin
			if (t == AXI_TIMEOUT) begin
				$display("timeout: no write response for address %h", addr);
				end_with_fail();
			end
			t++;
			@(posedge clk50);
		end
		check_reg("write response", 32'(2'b00), 32'(s_axi_bresp));
		s_axi_bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [`W_AXI_ADDR-1:0] addr, output logic [31:0] data);
		int t;
		@(posedge clk50);
		s_axi_araddr <= addr;
		s_axi_arvalid <= 1'b1;
		s_axi_rready <= 1'b1;
		t = 0;
		@(posedge clk50);
		while (!s_axi_arready) begin
			if (t == AXI_TIMEOUT) begin
				$display("timeout: read of address %h was never accepted", addr);
				end_with_fail();
			end
			t++;
			@(posedge clk50);
		end
		s_axi_arvalid <= 1'b0;
		t = 0;
		@(posedge clk50);
		while (!s_axi_rvalid) begin
			if (t == AXI_TIMEOUT) begin
				$display("timeout: no read data for address %h", addr);
				end_with_fail();
			end
			t++;
			@(posedge clk50);
		end
		data = s_axi_rdata;
		check_reg("read response", 32'(2'b00), 32'(s_axi_rresp));
		s_axi_rready <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// serial frame decoder on the falling edges of sclk
	////////////////////////////////////////////////////////////////////////////

	initial begin : frame_decoder
		logic [`W_DAC_FRAME-1:0] bits;
		forever begin
			@(negedge dac_nsync);
			bits = '0;
			for (int n = 0; n < `W_DAC_FRAME; n++) begin
				@(negedge dac_sclk);
				bits = {bits[`W_DAC_FRAME-2:0], dac_din};	// msb first
			end
			@(posedge dac_nsync);
			frames.push_back(bits);
		end
	end

	task automatic wait_frame(input string name, output logic [`W_DAC_FRAME-1:0] f);
		int t;
		t = 0;
		while (frames.size() == 0) begin
			if (t == FRAME_TIMEOUT) begin
				$display("timeout: no DAC frame arrived during %s", name);
				end_with_fail();
			end
			t++;
			@(posedge clk50);
		end
		f = frames.pop_front();
	endtask

	// bounded window where nsync must stay high
	task automatic expect_no_frame(input string name);
		for (int t = 0; t < QUIET_CYCLES; t++) begin
			@(posedge clk50);
			if (!dac_nsync || frames.size() != 0) begin
				$display("an unexpected DAC frame started during %s", name);
				end_with_fail();
			end
		end
	endtask

	task automatic send_sample(input pid_pkg::adc_chan_t ch, input pid_pkg::sample_t s);
		@(posedge clk50);
		sample_in <= {1'b1, ch, s};
		@(posedge clk50);
		sample_in.valid <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model of the stage rules
	////////////////////////////////////////////////////////////////////////////

	task automatic model_step(input entry_t en, input pid_pkg::sample_t s, output logic hit,
			output pid_pkg::dac_chan_t dch, output pid_pkg::dac_code_t code);
		longint acc;
		longint err;
		longint pid_sum;
		longint biased;
		pid_pkg::sample_t avg;
		pid_pkg::pid_word_t pid_w;
		logic [2:0] rt;
		int c;
		c = en.chan;
		hit = 1'b0;
		dch = '0;
		code = '0;
		acc = osf_sum[c] + longint'(s);
		if (osf_cnt[c] < (1 << en.osm) - 1) begin	// group still filling
			osf_sum[c] = acc;
			osf_cnt[c]++;
			return;
		end
		osf_sum[c] = 0;
		osf_cnt[c] = 0;
		avg = pid_pkg::sample_t'(acc >>> en.osm);	// average of 2^osm samples
		err = longint'(en.setp) - longint'(avg);
		if (en.ctrl[c]) begin
			integ_m[c] = integ_m[c] + int'(longint'(en.i) * err);
			pid_sum = longint'(en.p) * err + longint'(integ_m[c]);
			pid_w = pid_sum[`W_PID+`PID_SHIFT-1:`PID_SHIFT];	// scaled by 2^-PID_SHIFT
		end else begin
			pid_w = '0;		// unlocked
		end
		biased = longint'(en.oinit) + longint'(pid_w);
		if (biased < longint'(en.omin)) code = en.omin;
		else if (biased > longint'(en.omax)) code = en.omax;
		else code = pid_pkg::dac_code_t'(biased);
		rt = en.route[4*c +: 3];
		hit = rt[2];
		dch = rt[1:0];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	function automatic entry_t make_entry(input logic [15:0] setp, p, i, input logic [2:0] osm,
			input logic [15:0] omin, omax, oinit, input logic [7:0] route,
			input logic [9:0] ctrl, input logic chan, input logic [3:0] n_samp,
			input logic [15:0] base, mask);
		entry_t en;
		en.setp = setp;
		en.p = p;
		en.i = i;
		en.osm = osm;
		en.omin = omin;
		en.omax = omax;
		en.oinit = oinit;
		en.route = route;
		en.ctrl = ctrl;
		en.chan = chan;
		en.n_samp = n_samp;
		en.base = base;
		en.mask = mask;
		return en;
	endfunction

	task automatic build_table();
		// setp p i osm omin omax oinit route ctrl chan n base mask
		tname[0] = "proportional";
		tbl[0] = make_entry(16'd1000, 16'd32, 16'd0, 3'd0, 16'h0000, 16'hFFFF, 16'h8000,
			8'h05, 10'h001, 1'b0, 4'd4, 16'h0000, 16'h03FF);
		tname[1] = "integral";
		tbl[1] = make_entry(16'd1000, 16'd16, 16'd8, 3'd0, 16'h0000, 16'hFFFF, 16'h8000,
			8'h05, 10'h001, 1'b0, 4'd4, 16'h0000, 16'h03FF);
		tname[2] = "integral clear";	// clear pulse for ch0
		tbl[2] = make_entry(16'd1000, 16'd16, 16'd8, 3'd0, 16'h0000, 16'hFFFF, 16'h8000,
			8'h05, 10'h101, 1'b0, 4'd3, 16'h0000, 16'h03FF);
		tname[3] = "oversample";
		tbl[3] = make_entry(16'd1000, 16'd16, 16'd0, 3'd2, 16'h0000, 16'hFFFF, 16'h8000,
			8'h05, 10'h101, 1'b0, 4'd8, 16'h0000, 16'h0FFF);
		tname[4] = "clamp high";
		tbl[4] = make_entry(16'h4000, 16'h0100, 16'd0, 3'd0, 16'h4000, 16'hC000, 16'h8000,
			8'h05, 10'h001, 1'b0, 4'd2, 16'hC000, 16'h00FF);
		tname[5] = "clamp low";
		tbl[5] = make_entry(16'hC000, 16'h0100, 16'd0, 3'd0, 16'h4000, 16'hC000, 16'h8000,
			8'h05, 10'h001, 1'b0, 4'd2, 16'h7000, 16'h00FF);
		tname[6] = "lock off";
		tbl[6] = make_entry(16'd1000, 16'd32, 16'd8, 3'd0, 16'h0000, 16'hFFFF, 16'h1234,
			8'h05, 10'h000, 1'b0, 4'd2, 16'h0000, 16'h0FFF);
		tname[7] = "route ch1";		// ch1 to dac 3
		tbl[7] = make_entry(16'd1000, 16'd16, 16'd4, 3'd0, 16'h0000, 16'hFFFF, 16'h8000,
			8'h75, 10'h003, 1'b1, 4'd3, 16'h0000, 16'h03FF);
		tname[8] = "route ch0";
		tbl[8] = make_entry(16'd1000, 16'd16, 16'd4, 3'd0, 16'h0000, 16'hFFFF, 16'h8000,
			8'h75, 10'h003, 1'b0, 4'd2, 16'h0000, 16'h03FF);
		tname[9] = "unrouted";
		tbl[9] = make_entry(16'd1000, 16'd16, 16'd4, 3'd0, 16'h0000, 16'hFFFF, 16'h8000,
			8'h05, 10'h003, 1'b1, 4'd2, 16'h0000, 16'h03FF);
	endtask

	// every field reads back and bits past its width read zero
	task automatic check_readback();
		rb_row_t rb [N_RB];
		logic [31:0] rd;
		rb[0] = {`REG_SETP, 32'hABCD_1234, 32'h0000_1234};
		rb[1] = {`REG_PCF, 32'h0000_FEDC, 32'h0000_FEDC};
		rb[2] = {`REG_ICF, 32'h0000_0042, 32'h0000_0042};
		rb[3] = {`REG_OSM, 32'hFFFF_FFFD, 32'h0000_0005};
		rb[4] = {`REG_OMIN, 32'h0000_0100, 32'h0000_0100};
		rb[5] = {`REG_OMAX, 32'h0000_FF00, 32'h0000_FF00};
		rb[6] = {`REG_OINIT, 32'h0001_7FFF, 32'h0000_7FFF};
		rb[7] = {`REG_ROUTE, 32'hFFFF_FF75, 32'h0000_0075};
		rb[8] = {`REG_CTRL, 32'h0000_0303, 32'h0000_0003};	// clear bits read zero
		rb[9] = {8'h24, 32'hFFFF_FFFF, 32'h0000_0000};		// unknown addresses
		rb[10] = {8'h80, 32'hFFFF_FFFF, 32'h0000_0000};
		for (int r = 0; r < N_RB; r++) axi_write(rb[r].addr, rb[r].wdat);
		for (int r = 0; r < N_RB; r++) begin
			axi_read(rb[r].addr, rd);
			check_reg($sformatf("readback %h", rb[r].addr), rb[r].exp, rd);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		entry_t en;
		pid_pkg::sample_t s;
		logic [31:0] rnd;
		logic hit;
		pid_pkg::dac_chan_t dch;
		pid_pkg::dac_code_t code;
		logic [`W_DAC_FRAME-1:0] f;
		seed = 32'h43df;
		rst_n = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		sample_in = '0;
		for (int c = 0; c < `N_ADC; c++) begin
			osf_sum[c] = 0;
			osf_cnt[c] = 0;
			integ_m[c] = 0;
		end
		repeat (16) @(posedge clk50);
		rst_n <= 1'b1;
		@(posedge clk50);

		// idle levels after reset and the tied dac pins
		check_pin("reset nsync", 1'b1, dac_nsync);
		check_pin("reset sclk", 1'b0, dac_sclk);
		check_pin("reset din", 1'b0, dac_din);
		check_pin("tied nldac", 1'b0, dac_nldac);
		check_pin("tied nclr", 1'b1, dac_nclr);
		check_pin("reset awready", 1'b0, s_axi_awready);
		check_pin("reset wready", 1'b0, s_axi_wready);
		check_pin("reset bvalid", 1'b0, s_axi_bvalid);
		check_pin("reset arready", 1'b0, s_axi_arready);
		check_pin("reset rvalid", 1'b0, s_axi_rvalid);

		check_readback();
		build_table();

		for (int e = 0; e < N_ENT; e++) begin
			en = tbl[e];
			axi_write(`REG_SETP, 32'(en.setp));
			axi_write(`REG_PCF, 32'(en.p));
			axi_write(`REG_ICF, 32'(en.i));
			axi_write(`REG_OSM, 32'(en.osm));
			axi_write(`REG_OMIN, 32'(en.omin));
			axi_write(`REG_OMAX, 32'(en.omax));
			axi_write(`REG_OINIT, 32'(en.oinit));
			axi_write(`REG_ROUTE, 32'(en.route));
			axi_write(`REG_CTRL, 32'(en.ctrl));
			// integrator is zero while unlocked and after a clear
			for (int c = 0; c < `N_ADC; c++) begin
				if (!en.ctrl[c] || en.ctrl[8+c]) integ_m[c] = 0;
			end
			for (int k = 0; k < int'(en.n_samp); k++) begin
				rnd = $random(seed);
				s = en.base + (rnd[15:0] & en.mask);
				model_step(en, s, hit, dch, code);
				send_sample(en.chan, s);
				if (hit) begin
					wait_frame(tname[e], f);
					// write command then zero padded channel
					check_reg(tname[e], {26'h0, `DAC_CMD_WRITE, 2'b00}, {26'h0, f[23:18]});
					check_chan(tname[e], dch, f[17:16]);
					check_code(tname[e], code, f[15:0]);
				end else begin
					expect_no_frame(tname[e]);
				end
			end
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
